//--- verilog/bpu_defs.svh
`ifndef BPU_DEFS_SVH
`define BPU_DEFS_SVH

// counter table index width, 2**11 = 2048 two-bit counters
`define BPU_BPT_INDEX_BITS 11

// target buffer index width, 2**6 = 64 entries
`define BPU_BTB_INDEX_BITS 6

// first fetch address out of reset
`define BPU_RESET_PC 32'h0000_0200

`endif

//--- verilog/bpu_pkg.sv
`default_nettype none

package bpu_pkg;

    // pc or branch target address
    typedef logic [31:0] word_t;

    // two-bit saturating counter, upper bit is the predicted direction
    typedef enum logic [1:0] {
        st_strong_nt = 2'b00,
        st_weak_nt   = 2'b01,
        st_weak_t    = 2'b10,
        st_strong_t  = 2'b11
    } bpt_state_t;

    // outcome reported by the resolution stage to the counter table
    typedef logic [1:0] res_outcome_t;

    localparam res_outcome_t outcome_taken     = 2'b10;
    localparam res_outcome_t outcome_not_taken = 2'b01;
    // any other code leaves the counter alone
    localparam res_outcome_t outcome_hold      = 2'b00;

endpackage

`default_nettype wire

//--- verilog/bpt_tbp.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_defs.svh"

module bpt_tbp
    import bpu_pkg::*;
#(
    parameter int size = `BPU_BPT_INDEX_BITS
) (
    input  wire logic         CLK,
    input  wire logic         nRST,
    input  word_t             pc_fetch,
    output logic              pred_fetch,
    input  word_t             pc_res,
    input  wire logic         enable_res,
    input  res_outcome_t      taken_res
);

    localparam int entries = 2 ** size;

    bpt_state_t counters [entries];

    logic [size-1:0] fetch_idx;
    logic [size-1:0] res_idx;

    bpt_state_t cur_state;
    bpt_state_t next_state;

    // both ports index by word address
    assign fetch_idx = pc_fetch[size+1:2];
    assign res_idx   = pc_res[size+1:2];

    // fetch side, the upper counter bit is the direction
    assign pred_fetch = counters[fetch_idx][1];

    assign cur_state = counters[res_idx];

    always_comb begin
        next_state = cur_state;
        case (cur_state)
            st_strong_t: begin
                if (taken_res == outcome_not_taken) begin
                    next_state = st_weak_t;
                end
            end
            st_weak_t: begin
                if (taken_res == outcome_taken) begin
                    next_state = st_strong_t;
                end else if (taken_res == outcome_not_taken) begin
                    next_state = st_strong_nt;
                end
            end
            st_strong_nt: begin
                if (taken_res == outcome_taken) begin
                    next_state = st_weak_nt;
                end
            end
            st_weak_nt: begin
                // a taken outcome jumps straight to strongly taken
                if (taken_res == outcome_taken) begin
                    next_state = st_strong_t;
                end else if (taken_res == outcome_not_taken) begin
                    next_state = st_strong_nt;
                end
            end
            default: begin
                next_state = cur_state;
            end
        endcase
    end

    // read before write, a same-cycle lookup sees the old counter
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            counters <= '{default: st_strong_nt};
        end else if (enable_res) begin
            counters[res_idx] <= next_state;
        end
    end

endmodule

`default_nettype wire

//--- verilog/branch_target_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_defs.svh"

module branch_target_buffer
    import bpu_pkg::*;
#(
    parameter int index_bits = `BPU_BTB_INDEX_BITS
) (
    input  wire logic   CLK,
    input  wire logic   nRST,
    input  word_t       pc_fetch,
    output logic        btb_hit,
    output word_t       btb_target_fetch,
    input  wire logic   btb_we,
    input  word_t       btb_pc,
    input  word_t       btb_target
);

    localparam int entries  = 2 ** index_bits;
    // tag is everything above the index, bits 1:0 are always zero
    localparam int tag_bits = 32 - index_bits - 2;

    logic [entries-1:0]  valid_q;
    logic [tag_bits-1:0] tag_q    [entries];
    word_t               target_q [entries];

    logic [index_bits-1:0] fetch_idx;
    logic [tag_bits-1:0]   fetch_tag;
    logic [index_bits-1:0] wr_idx;
    logic [tag_bits-1:0]   wr_tag;

    assign fetch_idx = pc_fetch[index_bits+1:2];
    assign fetch_tag = pc_fetch[31:index_bits+2];
    assign wr_idx    = btb_pc[index_bits+1:2];
    assign wr_tag    = btb_pc[31:index_bits+2];

    // lookup
    assign btb_hit          = valid_q[fetch_idx] && (tag_q[fetch_idx] == fetch_tag);
    assign btb_target_fetch = target_q[fetch_idx];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_q <= '0;
        end else if (btb_we) begin
            valid_q[wr_idx] <= 1'b1;
        end
    end

    // tag and target are only meaningful once the valid bit is set
    always_ff @(posedge CLK) begin
        if (btb_we) begin
            tag_q[wr_idx]    <= wr_tag;
            target_q[wr_idx] <= btb_target;
        end
    end

endmodule

`default_nettype wire

//--- verilog/branch_resolver.sv
`timescale 1ns/1ps
`default_nettype none

module branch_resolver
    import bpu_pkg::*;
(
    input  wire logic     res_valid,
    input  word_t         res_pc,
    input  wire logic     res_taken,
    input  word_t         res_target,
    input  wire logic     res_pred_taken,
    input  word_t         res_pred_target,
    output logic          mispredict,
    output word_t         redirect_pc,
    output logic          enable_res,
    output word_t         pc_res,
    output res_outcome_t  taken_res,
    output logic          btb_we,
    output word_t         btb_pc,
    output word_t         btb_target
);

    logic dir_wrong;
    logic target_wrong;

    // direction error, or right direction but wrong target
    assign dir_wrong    = res_taken != res_pred_taken;
    assign target_wrong = res_taken && res_pred_taken && (res_target != res_pred_target);

    assign mispredict = res_valid && (dir_wrong || target_wrong);

    // correct path after the branch
    assign redirect_pc = res_taken ? res_target : res_pc + 32'd4;

    // counter training happens on every resolved branch
    assign enable_res = res_valid;
    assign pc_res     = res_pc;

    always_comb begin
        if (!res_valid) begin
            taken_res = outcome_hold;
        end else if (res_taken) begin
            taken_res = outcome_taken;
        end else begin
            taken_res = outcome_not_taken;
        end
    end

    // only taken branches allocate a buffer entry
    assign btb_we     = res_valid && res_taken;
    assign btb_pc     = res_pc;
    assign btb_target = res_target;

endmodule

`default_nettype wire

//--- verilog/fetch_pc_gen.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_defs.svh"

module fetch_pc_gen
    import bpu_pkg::*;
(
    input  wire logic   CLK,
    input  wire logic   nRST,
    input  wire logic   stall,
    input  wire logic   mispredict,
    input  word_t       redirect_pc,
    input  wire logic   pred_fetch,
    input  wire logic   btb_hit,
    input  word_t       btb_target_fetch,
    output word_t       pc_fetch,
    output logic        pred_taken,
    output word_t       pred_target
);

    word_t pc_seq;
    word_t pc_next;

    assign pc_seq = pc_fetch + 32'd4;

    // taken needs both a taken counter and a known target
    assign pred_taken = pred_fetch && btb_hit;

    // predicted next fetch address for the current pc
    assign pred_target = pred_taken ? btb_target_fetch : pc_seq;

    // redirect wins over stall
    always_comb begin
        if (mispredict) begin
            pc_next = redirect_pc;
        end else if (stall) begin
            pc_next = pc_fetch;
        end else begin
            pc_next = pred_target;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            pc_fetch <= `BPU_RESET_PC;
        end else begin
            pc_fetch <= pc_next;
        end
    end

endmodule

`default_nettype wire

//--- verilog/branch_predict_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_defs.svh"

module branch_predict_unit
    import bpu_pkg::*;
(
    input  wire logic   CLK,
    input  wire logic   nRST,
    input  wire logic   stall,
    input  wire logic   res_valid,
    input  word_t       res_pc,
    input  wire logic   res_taken,
    input  word_t       res_target,
    input  wire logic   res_pred_taken,
    input  word_t       res_pred_target,
    output word_t       pc_fetch,
    output logic        pred_taken,
    output word_t       pred_target,
    output logic        mispredict,
    output word_t       redirect_pc
);

    // fetch side lookups
    logic         pred_fetch;
    logic         btb_hit;
    word_t        btb_target_fetch;

    // training from resolution
    logic         enable_res;
    word_t        pc_res;
    res_outcome_t taken_res;
    logic         btb_we;
    word_t        btb_pc;
    word_t        btb_target;

    bpt_tbp #(
        .size       (`BPU_BPT_INDEX_BITS)
    ) i_bpt_tbp (
        .CLK        (CLK),
        .nRST       (nRST),
        .pc_fetch   (pc_fetch),
        .pred_fetch (pred_fetch),
        .pc_res     (pc_res),
        .enable_res (enable_res),
        .taken_res  (taken_res)
    );

    branch_target_buffer #(
        .index_bits       (`BPU_BTB_INDEX_BITS)
    ) i_btb (
        .CLK              (CLK),
        .nRST             (nRST),
        .pc_fetch         (pc_fetch),
        .btb_hit          (btb_hit),
        .btb_target_fetch (btb_target_fetch),
        .btb_we           (btb_we),
        .btb_pc           (btb_pc),
        .btb_target       (btb_target)
    );

    branch_resolver i_resolver (
        .res_valid       (res_valid),
        .res_pc          (res_pc),
        .res_taken       (res_taken),
        .res_target      (res_target),
        .res_pred_taken  (res_pred_taken),
        .res_pred_target (res_pred_target),
        .mispredict      (mispredict),
        .redirect_pc     (redirect_pc),
        .enable_res      (enable_res),
        .pc_res          (pc_res),
        .taken_res       (taken_res),
        .btb_we          (btb_we),
        .btb_pc          (btb_pc),
        .btb_target      (btb_target)
    );

    fetch_pc_gen i_fetch_pc_gen (
        .CLK              (CLK),
        .nRST             (nRST),
        .stall            (stall),
        .mispredict       (mispredict),
        .redirect_pc      (redirect_pc),
        .pred_fetch       (pred_fetch),
        .btb_hit          (btb_hit),
        .btb_target_fetch (btb_target_fetch),
        .pc_fetch         (pc_fetch),
        .pred_taken       (pred_taken),
        .pred_target      (pred_target)
    );

endmodule

`default_nettype wire

//--- bench/tb_branch_predict_unit.sv
`timescale 1ns/1ps
`default_nettype none

`include "bpu_defs.svh"

module tb_branch_predict_unit;

    localparam int cnt_bits      = `BPU_BPT_INDEX_BITS;
    localparam int btb_bits      = `BPU_BTB_INDEX_BITS;
    localparam int reset_timeout = 50;

    // one row per cycle where use_model takes the prediction from the model
    typedef struct packed {
        logic [3:0]  test_id;
        logic        stall;
        logic        valid;
        logic [31:0] pc;
        logic        taken;
        logic [31:0] target;
        logic        use_model;
        logic        pred_taken;
        logic [31:0] pred_target;
    } row_t;

    logic        CLK;
    logic        nRST;
    logic        stall;
    logic        res_valid;
    logic [31:0] res_pc;
    logic        res_taken;
    logic [31:0] res_target;
    logic        res_pred_taken;
    logic [31:0] res_pred_target;
    logic [31:0] pc_fetch;
    logic        pred_taken;
    logic [31:0] pred_target;
    logic        mispredict;
    logic [31:0] redirect_pc;

    // reference model of counters, buffer and fetch pc
    logic [1:0]  model_cnt    [2**cnt_bits];
    logic        model_valid  [2**btb_bits];
    logic [31:0] model_tag    [2**btb_bits];
    logic [31:0] model_target [2**btb_bits];
    logic [31:0] model_pc;
    logic        exp_mispredict;
    logic [31:0] exp_redirect;

    row_t rows [$];
    int   checks;
    int   errors;
    int   test_checks;
    int   test_errors;
    int   tests_passed;
    int   tests_failed;

    branch_predict_unit i_dut (
        .CLK             (CLK),
        .nRST            (nRST),
        .stall           (stall),
        .res_valid       (res_valid),
        .res_pc          (res_pc),
        .res_taken       (res_taken),
        .res_target      (res_target),
        .res_pred_taken  (res_pred_taken),
        .res_pred_target (res_pred_target),
        .pc_fetch        (pc_fetch),
        .pred_taken      (pred_taken),
        .pred_target     (pred_target),
        .mispredict      (mispredict),
        .redirect_pc     (redirect_pc)
    );

    initial begin
        CLK = 1'b0;
        forever #5 CLK = ~CLK;
    end

    initial begin
        nRST = 1'b0;
        repeat (3) @(posedge CLK);
        #1 nRST = 1'b1;
    end

    function automatic int cnt_index(input logic [31:0] pc);
        return int'((pc >> 2) & ((32'd1 << cnt_bits) - 1));
    endfunction

    function automatic int btb_index(input logic [31:0] pc);
        return int'((pc >> 2) & ((32'd1 << btb_bits) - 1));
    endfunction

    function automatic logic model_taken(input logic [31:0] pc);
        int  bi;
        logic hit;
        bi  = btb_index(pc);
        hit = model_valid[bi] && (model_tag[bi] == (pc >> (btb_bits + 2)));
        return model_cnt[cnt_index(pc)][1] && hit;
    endfunction

    function automatic logic [31:0] model_next(input logic [31:0] pc);
        if (model_taken(pc)) begin
            return model_target[btb_index(pc)];
        end
        return pc + 32'd4;
    endfunction

    // 00 strong nt, 01 weak nt, 10 weak t, 11 strong t
    function automatic logic [1:0] next_count(input logic [1:0] state, input logic taken);
        case (state)
            2'b11:   return taken ? 2'b11 : 2'b10;
            2'b10:   return taken ? 2'b11 : 2'b00;
            2'b00:   return taken ? 2'b01 : 2'b00;
            default: return taken ? 2'b11 : 2'b00;
        endcase
    endfunction

    function automatic string test_name(input int id);
        case (id)
            1:       return "reset and sequential fetch";
            2:       return "counter transitions";
            3:       return "misprediction and redirect";
            4:       return "target buffer tags";
            default: return "counter aliasing";
        endcase
    endfunction

    task automatic add_row(input int id, input logic st, input logic valid,
                           input logic [31:0] pc, input logic taken, input logic [31:0] target,
                           input logic use_model, input logic ptaken, input logic [31:0] ptarget);
        row_t r;
        r.test_id     = id[3:0];
        r.stall       = st;
        r.valid       = valid;
        r.pc          = pc;
        r.taken       = taken;
        r.target      = target;
        r.use_model   = use_model;
        r.pred_taken  = ptaken;
        r.pred_target = ptarget;
        rows.push_back(r);
    endtask

    task automatic add_idle(input int id, input logic st);
        add_row(id, st, 1'b0, 32'h0, 1'b0, 32'h0, 1'b0, 1'b0, 32'h0);
    endtask

    task automatic add_resolve(input int id, input logic [31:0] pc, input logic taken,
                               input logic [31:0] target);
        add_row(id, 1'b0, 1'b1, pc, taken, target, 1'b1, 1'b0, 32'h0);
    endtask

    // taken branch reported as predicted not-taken so it always redirects
    task automatic add_redirect(input int id, input logic [31:0] pc, input logic [31:0] target);
        add_row(id, 1'b0, 1'b1, pc, 1'b1, target, 1'b0, 1'b0, pc + 32'd4);
    endtask

    task automatic build_table();
        logic [10:0] walk;
        repeat (4) add_idle(1, 1'b0);
        repeat (2) add_idle(1, 1'b1);
        add_idle(1, 1'b0);
        // walk the counter at 0x400 through every state and refetch 0x400 after each step
        walk = 11'b110_0010_1101;
        for (int k = 0; k < 11; k++) begin
            add_resolve(2, 32'h0000_0400, walk[k], 32'h0000_0800);
            add_redirect(2, 32'h0000_0304, 32'h0000_0400);
        end
        repeat (2) add_idle(2, 1'b0);
        // wrong direction and wrong target errors with some under stall
        add_row(3, 1'b1, 1'b1, 32'h0000_1000, 1'b1, 32'h0000_1800, 1'b0, 1'b0, 32'h0000_1004);
        add_idle(3, 1'b1);
        add_row(3, 1'b1, 1'b1, 32'h0000_1100, 1'b1, 32'h0000_1a00, 1'b0, 1'b1, 32'h0000_1900);
        add_row(3, 1'b0, 1'b1, 32'h0000_1200, 1'b0, 32'h0000_1300, 1'b0, 1'b1, 32'h0000_1300);
        add_row(3, 1'b0, 1'b1, 32'h0000_1000, 1'b0, 32'h0000_1800, 1'b0, 1'b0, 32'h0000_1004);
        add_idle(3, 1'b0);
        // 0x2010 and 0x3010 share a buffer entry
        add_resolve(4, 32'h0000_2010, 1'b1, 32'h0000_2400);
        add_resolve(4, 32'h0000_2010, 1'b1, 32'h0000_2400);
        add_redirect(4, 32'h0000_5000, 32'h0000_2010);
        add_idle(4, 1'b0);
        add_resolve(4, 32'h0000_3010, 1'b1, 32'h0000_2800);
        add_redirect(4, 32'h0000_5000, 32'h0000_2010);
        repeat (2) add_idle(4, 1'b0);
        // 0x6040 and 0x8040 share a counter
        add_resolve(5, 32'h0000_8040, 1'b1, 32'h0000_9000);
        add_resolve(5, 32'h0000_8040, 1'b1, 32'h0000_9000);
        add_redirect(5, 32'h0000_a100, 32'h0000_8040);
        add_idle(5, 1'b0);
        add_resolve(5, 32'h0000_6040, 1'b0, 32'h0000_7000);
        add_resolve(5, 32'h0000_6040, 1'b0, 32'h0000_7000);
        add_redirect(5, 32'h0000_a100, 32'h0000_8040);
        repeat (2) add_idle(5, 1'b0);
    endtask

    task automatic reset_model();
        for (int i = 0; i < 2**cnt_bits; i++) begin
            model_cnt[i] = 2'b00;
        end
        for (int i = 0; i < 2**btb_bits; i++) begin
            model_valid[i]  = 1'b0;
            model_tag[i]    = 32'h0;
            model_target[i] = 32'h0;
        end
        model_pc = `BPU_RESET_PC;
    endtask

    task automatic drive_row(input row_t r);
        stall      = r.stall;
        res_valid  = r.valid;
        res_pc     = r.pc;
        res_taken  = r.taken;
        res_target = r.target;
        if (r.use_model) begin
            res_pred_taken  = model_taken(r.pc);
            res_pred_target = model_next(r.pc);
        end else begin
            res_pred_taken  = r.pred_taken;
            res_pred_target = r.pred_target;
        end
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            errors++;
            test_errors++;
            $display("error: %s is 0x%08h, expected 0x%08h at %0t", name, got, exp, $time);
        end
    endtask

    task automatic check_cycle();
        // a taken branch misses on a wrong direction or a wrong target
        exp_mispredict = 1'b0;
        if (res_valid) begin
            if (res_taken) begin
                exp_mispredict = !res_pred_taken || (res_target != res_pred_target);
            end else begin
                exp_mispredict = res_pred_taken;
            end
        end
        if (res_taken) begin
            exp_redirect = res_target;
        end else begin
            exp_redirect = res_pc + 32'd4;
        end
        check_value("pc_fetch", pc_fetch, model_pc);
        check_value("pred_taken", 32'(pred_taken), 32'(model_taken(model_pc)));
        check_value("pred_target", pred_target, model_next(model_pc));
        check_value("mispredict", 32'(mispredict), 32'(exp_mispredict));
        check_value("redirect_pc", redirect_pc, exp_redirect);
    endtask

    task automatic update_model();
        logic [31:0] next_pc;
        int          ci;
        int          bi;
        // lookups see the state from before this edge
        if (exp_mispredict) begin
            next_pc = exp_redirect;
        end else if (stall) begin
            next_pc = model_pc;
        end else begin
            next_pc = model_next(model_pc);
        end
        if (res_valid) begin
            ci            = cnt_index(res_pc);
            model_cnt[ci] = next_count(model_cnt[ci], res_taken);
            if (res_taken) begin
                bi               = btb_index(res_pc);
                model_valid[bi]  = 1'b1;
                model_tag[bi]    = res_pc >> (btb_bits + 2);
                model_target[bi] = res_target;
            end
        end
        model_pc = next_pc;
    endtask

    task automatic report_test(input int id);
        if (test_errors == 0) begin
            tests_passed++;
            $display("test %0d %s: passed, %0d checks", id, test_name(id), test_checks);
        end else begin
            tests_failed++;
            $display("test %0d %s: failed, %0d of %0d checks wrong",
                     id, test_name(id), test_errors, test_checks);
        end
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        row_t cur;
        int   waited;
        // hold fetch while reset is released
        stall           = 1'b1;
        res_valid       = 1'b0;
        res_pc          = 32'h0;
        res_taken       = 1'b0;
        res_target      = 32'h0;
        res_pred_taken  = 1'b0;
        res_pred_target = 32'h0;
        checks          = 0;
        errors          = 0;
        test_checks     = 0;
        test_errors     = 0;
        tests_passed    = 0;
        tests_failed    = 0;
        waited          = 0;
        reset_model();
        build_table();
        while (nRST !== 1'b1 && waited < reset_timeout) begin
            @(negedge CLK);
            waited++;
        end
        if (nRST !== 1'b1) begin
            $display("reset was not released within %0d cycles", reset_timeout);
            $display("TESTS FAILED");
            $finish;
        end else begin
            @(posedge CLK);
            #1;
            for (int i = 0; i < rows.size(); i++) begin
                cur = rows[i];
                drive_row(cur);
                #4;
                check_cycle();
                update_model();
                if (i == rows.size() - 1 || rows[i+1].test_id != cur.test_id) begin
                    report_test(int'(cur.test_id));
                end
                @(posedge CLK);
                #1;
            end
            $display("tests passed %0d, tests failed %0d, checks %0d, errors %0d",
                     tests_passed, tests_failed, checks, errors);
            if (errors == 0 && tests_failed == 0) begin
                $display("TESTS PASSED");
            end else begin
                $display("TESTS FAILED");
            end
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+verilog
verilog/bpu_pkg.sv
verilog/bpt_tbp.sv
verilog/branch_target_buffer.sv
verilog/branch_resolver.sv
verilog/fetch_pc_gen.sv
verilog/branch_predict_unit.sv
bench/tb_branch_predict_unit.sv

//--- Bender.yml
package:
  name: branch_predict_unit

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/bpu_pkg.sv
      - verilog/bpt_tbp.sv
      - verilog/branch_target_buffer.sv
      - verilog/branch_resolver.sv
      - verilog/fetch_pc_gen.sv
      - verilog/branch_predict_unit.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/tb_branch_predict_unit.sv
